// File: verilog/ex_pkg.sv
// execute stage shared package with operation codes, register address type and widths
package ex_pkg;

    // destination register number width
    localparam int REG_ADDR_W = 5;

    // datapath width used when the top level is not overridden
    localparam int DATA_W_DEF = 32;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // operation codes numbered from zero in this order
    typedef enum logic [4:0] {
        OP_OR,
        OP_AND,
        OP_NOR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_CLZ,
        OP_CLO,
        OP_MULT,
        OP_MULTU,
        OP_MUL,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } alu_op_t;

    // result groups feeding the output register
    typedef enum logic [1:0] {
        RES_LOGIC_SHIFT,
        RES_ARITH,
        RES_MOVE,
        RES_MUL
    } res_sel_t;

endpackage

// File: verilog/ex_logic_shift.sv
// execute stage logic unit computing bitwise operations and barrel shifts
`timescale 1ns/1ns

module ex_logic_shift #(
    parameter int DATA_W = ex_pkg::DATA_W_DEF
) (
    input  ex_pkg::alu_op_t   op_i,
    input  logic [DATA_W-1:0] opa_i,
    input  logic [DATA_W-1:0] opb_i,
    output logic [DATA_W-1:0] res_o
);
    import ex_pkg::*;

    localparam int SH_W = $clog2(DATA_W);

    // shift amount taken from the low bits of opa
    logic [SH_W-1:0] shamt;

    assign shamt = opa_i[SH_W-1:0];

    always_comb
    begin
        case (op_i)
            OP_OR:   res_o = opa_i | opb_i;
            OP_AND:  res_o = opa_i & opb_i;
            OP_NOR:  res_o = ~(opa_i | opb_i);
            OP_XOR:  res_o = opa_i ^ opb_i;
            // opb is the value being shifted
            OP_SLL:  res_o = opb_i << shamt;
            OP_SRL:  res_o = opb_i >> shamt;
            // sign bit of opb fills from the left
            OP_SRA:  res_o = $signed(opb_i) >>> shamt;
            default: res_o = '0;
        endcase
    end

endmodule

// File: verilog/ex_arith.sv
// execute stage arithmetic unit with add/sub, set-less-than, overflow and leading count
`timescale 1ns/1ns

module ex_arith #(
    parameter int DATA_W = ex_pkg::DATA_W_DEF
) (
    input  ex_pkg::alu_op_t   op_i,
    input  logic [DATA_W-1:0] opa_i,
    input  logic [DATA_W-1:0] opb_i,
    output logic [DATA_W-1:0] res_o,
    output logic              ovf_o
);
    import ex_pkg::*;

    localparam int MSB = DATA_W - 1;

    logic              sub_en;
    logic [DATA_W-1:0] addend;
    logic [DATA_W:0]   sum_full;
    logic [DATA_W-1:0] sum;
    logic              ovf_raw;
    logic              lt_signed;
    logic              lt_unsigned;

    // number of zero bits above the highest set bit
    function automatic logic [DATA_W-1:0] lead_zeros(input logic [DATA_W-1:0] v);
        logic [DATA_W-1:0] cnt;
        logic              hit;
        cnt = '0;
        hit = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--)
        begin
            if (v[i])
                hit = 1'b1;
            else if (!hit)
                cnt = cnt + 1'b1;
        end
        return cnt;
    endfunction

    // compares also go through the subtractor
    assign sub_en = (op_i == OP_SUB) || (op_i == OP_SUBU) ||
                    (op_i == OP_SLT) || (op_i == OP_SLTU);

    // invert opb and add the one through the carry in
    assign addend   = sub_en ? ~opb_i : opb_i;
    assign sum_full = {1'b0, opa_i} + {1'b0, addend} + {{DATA_W{1'b0}}, sub_en};
    assign sum      = sum_full[MSB:0];

    // same-sign addends with a sum of the other sign
    assign ovf_raw = (opa_i[MSB] == addend[MSB]) && (sum[MSB] != opa_i[MSB]);

    // difference sign flipped back when it overflowed
    assign lt_signed = sum[MSB] ^ ovf_raw;

    // no carry out means opa borrowed
    assign lt_unsigned = !sum_full[DATA_W];

    // only the trapping forms report overflow
    assign ovf_o = ((op_i == OP_ADD) || (op_i == OP_SUB)) && ovf_raw;

    always_comb
    begin
        case (op_i)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: res_o = sum;
            OP_SLT:  res_o = {{MSB{1'b0}}, lt_signed};
            OP_SLTU: res_o = {{MSB{1'b0}}, lt_unsigned};
            OP_CLZ:  res_o = lead_zeros(opa_i);
            // leading ones are the leading zeros of the inverse
            OP_CLO:  res_o = lead_zeros(~opa_i);
            default: res_o = '0;
        endcase
    end

endmodule

// File: verilog/ex_mul_iter.sv
// iterative shift-add multiplier with sign correction for signed operands
`timescale 1ns/1ns

module ex_mul_iter #(
    parameter int DATA_W = ex_pkg::DATA_W_DEF
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                start_i,
    input  logic                signed_i,
    input  logic [DATA_W-1:0]   a_i,
    input  logic [DATA_W-1:0]   b_i,
    output logic                done_o,
    output logic [2*DATA_W-1:0] prod_o
);
    localparam int CNT_W = $clog2(DATA_W + 1);
    localparam int MSB   = DATA_W - 1;

    logic [CNT_W-1:0]    cnt;
    logic [DATA_W-1:0]   mag_a;
    logic [DATA_W-1:0]   mag_b;
    logic [DATA_W-1:0]   mcand;
    logic [2*DATA_W-1:0] acc;
    logic [DATA_W:0]     part_sum;
    logic                neg;

    // magnitudes of negative signed operands
    assign mag_a = (signed_i && a_i[MSB]) ? (~a_i + 1'b1) : a_i;
    assign mag_b = (signed_i && b_i[MSB]) ? (~b_i + 1'b1) : b_i;

    // upper half plus multiplicand when the current multiplier bit is set
    assign part_sum = {1'b0, acc[2*DATA_W-1:DATA_W]} + (acc[0] ? {1'b0, mcand} : '0);

    // product held until the next start
    assign prod_o = neg ? (~acc + 1'b1) : acc;

    // iteration counter is nonzero while busy
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            cnt    <= '0;
            done_o <= 1'b0;
        end
        else
        begin
            done_o <= 1'b0;
            if (start_i)
                cnt <= CNT_W'(DATA_W);
            else if (cnt != '0)
            begin
                cnt    <= cnt - 1'b1;
                done_o <= (cnt == CNT_W'(1));
            end
        end
    end

    // multiplier sits in the low half and shifts out one bit per step
    always_ff @(posedge clk)
    begin
        if (start_i)
        begin
            mcand <= mag_a;
            acc   <= {{DATA_W{1'b0}}, mag_b};
            neg   <= signed_i && (a_i[MSB] ^ b_i[MSB]);
        end
        else if (cnt != '0)
        begin
            acc <= {part_sum, acc[DATA_W-1:1]};
        end
    end

endmodule

// File: verilog/ex_ctrl.sv
// execute stage control with handshakes, multiply sequencing, HI/LO and result register
`timescale 1ns/1ns

module ex_ctrl #(
    parameter int DATA_W = ex_pkg::DATA_W_DEF
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  ex_pkg::alu_op_t     aluop_i,
    input  logic [DATA_W-1:0]   reg1_i,
    input  logic [DATA_W-1:0]   reg2_i,
    input  ex_pkg::reg_addr_t   wd_i,
    input  logic                wreg_i,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output ex_pkg::reg_addr_t   wd_o,
    output logic                wreg_o,
    output logic [DATA_W-1:0]   wdata_o,
    output logic                overflow_o,
    output ex_pkg::alu_op_t     op_o,
    output logic [DATA_W-1:0]   opa_o,
    output logic [DATA_W-1:0]   opb_o,
    input  logic [DATA_W-1:0]   logic_shift_res_i,
    input  logic [DATA_W-1:0]   arith_res_i,
    input  logic                ovf_i,
    output logic                mul_start_o,
    output logic                mul_signed_o,
    output logic [DATA_W-1:0]   mul_a_o,
    output logic [DATA_W-1:0]   mul_b_o,
    input  logic                mul_done_i,
    input  logic [2*DATA_W-1:0] mul_prod_i
);
    import ex_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        MUL_START,
        MUL_WAIT
    } state_t;

    state_t            state;
    alu_op_t           op_q;
    logic [DATA_W-1:0] opa_q;
    logic [DATA_W-1:0] opb_q;
    reg_addr_t         wd_q;
    logic              wreg_q;
    logic [DATA_W-1:0] hi_q;
    logic [DATA_W-1:0] lo_q;
    logic              busy;
    logic              accept;
    logic              is_mul;
    logic              mul_fin;
    logic              load_out;
    res_sel_t          res_sel;
    logic [DATA_W-1:0] move_res;
    logic [DATA_W-1:0] res_mux;

    function automatic res_sel_t res_group(input alu_op_t op);
        case (op)
            OP_OR, OP_AND, OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA: return RES_LOGIC_SHIFT;
            OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO: return RES_MOVE;
            OP_MULT, OP_MULTU, OP_MUL: return RES_MUL;
            default: return RES_ARITH;
        endcase
    endfunction

    // new work only when idle and the result slot is free or draining
    assign busy       = (state != IDLE);
    assign in_ready_o = !busy && (!out_valid_o || out_ready_i);
    assign accept     = in_valid_i && in_ready_o;

    // units see the latched operation while a multiply runs
    assign op_o  = busy ? op_q : aluop_i;
    assign opa_o = busy ? opa_q : reg1_i;
    assign opb_o = busy ? opb_q : reg2_i;

    assign res_sel  = res_group(op_o);
    assign is_mul   = (res_sel == RES_MUL);
    assign mul_fin  = (state == MUL_WAIT) && mul_done_i;
    assign load_out = (accept && !is_mul) || mul_fin;

    assign mul_start_o  = (state == MUL_START);
    assign mul_signed_o = (op_q != OP_MULTU);
    assign mul_a_o      = opa_q;
    assign mul_b_o      = opb_q;

    always_comb
    begin
        case (op_o)
            OP_MFHI: move_res = hi_q;
            OP_MFLO: move_res = lo_q;
            default: move_res = '0;
        endcase
        case (res_sel)
            RES_LOGIC_SHIFT: res_mux = logic_shift_res_i;
            RES_ARITH:       res_mux = arith_res_i;
            RES_MOVE:        res_mux = move_res;
            default:         res_mux = mul_prod_i[DATA_W-1:0];
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:      state <= (accept && is_mul) ? MUL_START : IDLE;
                MUL_START: state <= MUL_WAIT;
                MUL_WAIT:  state <= mul_done_i ? IDLE : MUL_WAIT;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op_q   <= aluop_i;
            opa_q  <= reg1_i;
            opb_q  <= reg2_i;
            wd_q   <= wd_i;
            wreg_q <= wreg_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
            out_valid_o <= 1'b0;
        else if (load_out)
            out_valid_o <= 1'b1;
        else if (out_ready_i)
            out_valid_o <= 1'b0;
    end

    // overflow blocks the register write
    always_ff @(posedge clk)
    begin
        if (load_out)
        begin
            wd_o       <= busy ? wd_q : wd_i;
            wreg_o     <= (busy ? wreg_q : wreg_i) && !ovf_i;
            wdata_o    <= res_mux;
            overflow_o <= ovf_i;
        end
    end

    // mul leaves HI/LO alone
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            hi_q <= '0;
            lo_q <= '0;
        end
        else if (accept && (aluop_i == OP_MTHI))
            hi_q <= reg1_i;
        else if (accept && (aluop_i == OP_MTLO))
            lo_q <= reg1_i;
        else if (mul_fin && (op_q != OP_MUL))
            {hi_q, lo_q} <= mul_prod_i;
    end

endmodule

// File: verilog/ex_top.sv
// execute stage top level joining control, logic/shift, arithmetic and multiplier units
`timescale 1ns/1ns

module ex_top #(
    parameter int DATA_W = ex_pkg::DATA_W_DEF
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  ex_pkg::alu_op_t   aluop_i,
    input  logic [DATA_W-1:0] reg1_i,
    input  logic [DATA_W-1:0] reg2_i,
    input  ex_pkg::reg_addr_t wd_i,
    input  logic              wreg_i,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output ex_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output logic [DATA_W-1:0] wdata_o,
    output logic              overflow_o
);
    import ex_pkg::*;

    // operation and operands to the combinational units
    alu_op_t             op;
    logic [DATA_W-1:0]   opa;
    logic [DATA_W-1:0]   opb;
    logic [DATA_W-1:0]   ls_res;
    logic [DATA_W-1:0]   arith_res;
    logic                ovf;

    // multiplier handshake
    logic                mul_start;
    logic                mul_signed;
    logic [DATA_W-1:0]   mul_a;
    logic [DATA_W-1:0]   mul_b;
    logic                mul_done;
    logic [2*DATA_W-1:0] mul_prod;

    ex_ctrl #(.DATA_W(DATA_W)) u_ctrl (
        .clk               (clk),
        .reset_i           (reset_i),
        .in_valid_i        (in_valid_i),
        .in_ready_o        (in_ready_o),
        .aluop_i           (aluop_i),
        .reg1_i            (reg1_i),
        .reg2_i            (reg2_i),
        .wd_i              (wd_i),
        .wreg_i            (wreg_i),
        .out_valid_o       (out_valid_o),
        .out_ready_i       (out_ready_i),
        .wd_o              (wd_o),
        .wreg_o            (wreg_o),
        .wdata_o           (wdata_o),
        .overflow_o        (overflow_o),
        .op_o              (op),
        .opa_o             (opa),
        .opb_o             (opb),
        .logic_shift_res_i (ls_res),
        .arith_res_i       (arith_res),
        .ovf_i             (ovf),
        .mul_start_o       (mul_start),
        .mul_signed_o      (mul_signed),
        .mul_a_o           (mul_a),
        .mul_b_o           (mul_b),
        .mul_done_i        (mul_done),
        .mul_prod_i        (mul_prod)
    );

    ex_logic_shift #(.DATA_W(DATA_W)) u_logic_shift (
        .op_i  (op),
        .opa_i (opa),
        .opb_i (opb),
        .res_o (ls_res)
    );

    ex_arith #(.DATA_W(DATA_W)) u_arith (
        .op_i  (op),
        .opa_i (opa),
        .opb_i (opb),
        .res_o (arith_res),
        .ovf_o (ovf)
    );

    ex_mul_iter #(.DATA_W(DATA_W)) u_mul (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (mul_start),
        .signed_i (mul_signed),
        .a_i      (mul_a),
        .b_i      (mul_b),
        .done_o   (mul_done),
        .prod_o   (mul_prod)
    );

endmodule

// File: sim/ex_clkgen.sv
// testbench clock source with a fixed period
`timescale 1ns/1ns

module ex_clkgen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial
    begin
        clk_o = 1'b0;
        forever
            #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

// File: sim/ex_assert.sv
// bound checks on execute stage reset, output hold and multiply back-pressure
`timescale 1ns/1ns

module ex_assert #(
    parameter int DATA_W = ex_pkg::DATA_W_DEF
) (
    input logic              clk,
    input logic              reset_i,
    input logic              in_valid_i,
    input logic              in_ready_i,
    input ex_pkg::alu_op_t   aluop_i,
    input logic              out_valid_i,
    input logic              out_ready_i,
    input ex_pkg::reg_addr_t wd_i,
    input logic              wreg_i,
    input logic [DATA_W-1:0] wdata_i,
    input logic              overflow_i
);
    import ex_pkg::*;

    // set when a multiply is taken in, cleared once its result shows up
    logic mul_pending;

    always_ff @(posedge clk)
    begin
        if (reset_i)
            mul_pending <= 1'b0;
        else if (in_valid_i && in_ready_i &&
                 (aluop_i == OP_MULT || aluop_i == OP_MULTU || aluop_i == OP_MUL))
            mul_pending <= 1'b1;
        else if (out_valid_i)
            mul_pending <= 1'b0;
    end

    reset_clears_valid: assert property (@(posedge clk) reset_i |=> !out_valid_i)
        else $error("out_valid_o high in the cycle after reset");

    output_held: assert property (@(posedge clk) disable iff (reset_i)
        (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(wd_i) &&
            $stable(wreg_i) && $stable(wdata_i) && $stable(overflow_i)))
        else $error("output fields changed while the result was stalled");

    mul_blocks_input: assert property (@(posedge clk) disable iff (reset_i)
        (mul_pending && !out_valid_i) |-> !in_ready_i)
        else $error("in_ready_o high while a multiply is still running");

endmodule

bind ex_top ex_assert #(.DATA_W(DATA_W)) u_assert (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_ready_i  (in_ready_o),
    .aluop_i     (aluop_i),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .wd_i        (wd_o),
    .wreg_i      (wreg_o),
    .wdata_i     (wdata_o),
    .overflow_i  (overflow_o)
);

// File: sim/ex_tb.sv
// testbench for the execute stage replaying stim vectors under random output back-pressure
`timescale 1ns/1ns

module ex_tb;
    import ex_pkg::*;

    localparam int DATA_W    = 32;
    localparam int MAX_VEC   = 64;
    localparam int LFSR_SEED = 5;

    logic              clk;
    logic              reset_i;
    logic              in_valid_i;
    logic              in_ready_o;
    alu_op_t           aluop_i;
    logic [DATA_W-1:0] reg1_i;
    logic [DATA_W-1:0] reg2_i;
    reg_addr_t         wd_i;
    logic              wreg_i;
    logic              out_valid_o;
    logic              out_ready_i;
    reg_addr_t         wd_o;
    logic              wreg_o;
    logic [DATA_W-1:0] wdata_o;
    logic              overflow_o;

    // vector table as read from the stim file
    int                vec_test  [MAX_VEC];
    logic [4:0]        vec_op    [MAX_VEC];
    logic [DATA_W-1:0] vec_reg1  [MAX_VEC];
    logic [DATA_W-1:0] vec_reg2  [MAX_VEC];
    reg_addr_t         vec_wd    [MAX_VEC];
    logic              vec_wreg  [MAX_VEC];
    logic [DATA_W-1:0] exp_wdata [MAX_VEC];
    logic              exp_wreg  [MAX_VEC];
    logic              exp_ovf   [MAX_VEC];

    int          num_vec     = 0;
    int          send_idx    = 0;
    int          recv_idx    = 0;
    int          err_count   = 0;
    int          check_count = 0;
    int          test_errs   = 0;
    int          test_vecs   = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;
    logic [15:0] lfsr;

    ex_clkgen #(.PERIOD_NS(20)) u_clkgen (.clk_o(clk));

    ex_top #(.DATA_W(DATA_W)) dut (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .aluop_i     (aluop_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .wd_i        (wd_i),
        .wreg_i      (wreg_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o),
        .wdata_o     (wdata_o),
        .overflow_o  (overflow_o)
    );

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 16'hB400;
        return n;
    endfunction

    // ready drops only when both of the two drawn bits are set
    task automatic draw_ready(output logic rdy);
        logic b0;
        logic b1;
        b0 = lfsr[0];
        lfsr = lfsr_step(lfsr);
        b1 = lfsr[0];
        lfsr = lfsr_step(lfsr);
        rdy = !(b0 && b1);
    endtask

    task automatic load_vectors(output bit ok);
        int    fd;
        int    n;
        string line;
        ok = 1'b0;
        fd = $fopen("sim/ex_stim.txt", "r");
        if (fd == 0)
            $display("cannot open sim/ex_stim.txt for reading");
        else
        begin
            while (!$feof(fd) && num_vec < MAX_VEC)
            begin
                line = "";
                n = $fgets(line, fd);
                // blank lines and lines starting with # carry no vector
                if (n > 0 && line.len() > 1 && line[0] != "#")
                begin
                    n = $sscanf(line, "%d %h %h %h %h %h %h %h %h", vec_test[num_vec],
                                vec_op[num_vec], vec_reg1[num_vec], vec_reg2[num_vec],
                                vec_wd[num_vec], vec_wreg[num_vec], exp_wdata[num_vec],
                                exp_wreg[num_vec], exp_ovf[num_vec]);
                    if (n == 9)
                        num_vec++;
                end
            end
            $fclose(fd);
            ok = (num_vec > 0);
            if (!ok)
                $display("no vectors found in sim/ex_stim.txt");
        end
    endtask

    task automatic check_result();
        int idx;
        idx = recv_idx;
        check_count++;
        if (wdata_o !== exp_wdata[idx])
        begin
            $display("CHECK FAILED test %0d vector %0d: wdata_o expected %h got %h",
                     vec_test[idx], idx, exp_wdata[idx], wdata_o);
            test_errs++;
            err_count++;
        end
        if (wreg_o !== exp_wreg[idx])
        begin
            $display("CHECK FAILED test %0d vector %0d: wreg_o expected %h got %h",
                     vec_test[idx], idx, exp_wreg[idx], wreg_o);
            test_errs++;
            err_count++;
        end
        if (overflow_o !== exp_ovf[idx])
        begin
            $display("CHECK FAILED test %0d vector %0d: overflow_o expected %h got %h",
                     vec_test[idx], idx, exp_ovf[idx], overflow_o);
            test_errs++;
            err_count++;
        end
        // wd tags each result with its operation, so order is checked here too
        if (wd_o !== vec_wd[idx])
        begin
            $display("CHECK FAILED test %0d vector %0d: wd_o expected %h got %h",
                     vec_test[idx], idx, vec_wd[idx], wd_o);
            test_errs++;
            err_count++;
        end
        test_vecs++;
        if (idx == num_vec - 1 || vec_test[idx + 1] != vec_test[idx])
        begin
            if (test_errs == 0)
                $display("test %0d passed, %0d vectors", vec_test[idx], test_vecs);
            else
                $display("test %0d failed, %0d mismatches in %0d vectors",
                         vec_test[idx], test_errs, test_vecs);
            test_errs = 0;
            test_vecs = 0;
        end
        recv_idx++;
    endtask

    // handshakes as seen at the rising edge before the DUT registers move
    task automatic sample_edge();
        if (out_valid_o && out_ready_i)
        begin
            if (recv_idx >= send_idx)
            begin
                $display("a result came out with no operation outstanding");
                err_count++;
            end
            else
                check_result();
        end
        if (in_valid_i && in_ready_o)
            send_idx++;
    endtask

    task automatic drive_inputs();
        logic rdy;
        draw_ready(rdy);
        out_ready_i = rdy;
        if (send_idx < num_vec)
        begin
            in_valid_i = 1'b1;
            aluop_i    = alu_op_t'(vec_op[send_idx]);
            reg1_i     = vec_reg1[send_idx];
            reg2_i     = vec_reg2[send_idx];
            wd_i       = vec_wd[send_idx];
            wreg_i     = vec_wreg[send_idx];
        end
        else
            in_valid_i = 1'b0;
    endtask

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
        begin
            $display("timeout after %0d cycles, %0d of %0d results received",
                     cycle_cnt, recv_idx, num_vec);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        bit ok;
        reset_i     = 1'b1;
        in_valid_i  = 1'b0;
        aluop_i     = OP_OR;
        reg1_i      = '0;
        reg2_i      = '0;
        wd_i        = '0;
        wreg_i      = 1'b0;
        out_ready_i = 1'b0;
        lfsr        = 16'(LFSR_SEED);
        load_vectors(ok);
        if (!ok)
        begin
            $display("Done: errors found");
            $finish;
        end
        else
        begin
            cycle_limit = num_vec * (DATA_W + 2) * 2 + 100;
            repeat (10) @(posedge clk);
            @(negedge clk);
            reset_i = 1'b0;
            drive_inputs();
            while (recv_idx < num_vec)
            begin
                @(posedge clk);
                sample_edge();
                @(negedge clk);
                drive_inputs();
            end
            $display("%0d vectors, %0d checks, %0d errors", num_vec, check_count, err_count);
            if (err_count == 0)
                $display("Done: no errors");
            else
                $display("Done: errors found");
            $finish;
        end
    end

endmodule

// File: sim/ex_stim.txt
# test op reg1 reg2 wd wreg, then expected wdata wreg overflow
# test number in decimal, every other field in hex, op in alu_op_t order from 0
1 00 f0f01234 0f0f0000 01 1 ffff1234 1 0
1 01 ff00ff00 0ff00ff0 02 1 0f000f00 1 0
1 02 0000ffff 00ff0000 03 1 ff000000 1 0
1 03 aaaa5555 ffff0000 04 1 55555555 1 0
1 04 0000001f 00000003 05 1 80000000 1 0
1 05 00000008 80001234 06 1 00800012 1 0
1 06 00000004 80000000 07 1 f8000000 1 0
1 06 0000001f 87654321 08 1 ffffffff 1 0
2 07 00000005 00000007 09 1 0000000c 1 0
2 07 7fffffff 00000001 0a 1 80000000 0 1
2 08 7fffffff 00000001 0b 1 80000000 1 0
2 09 80000000 00000001 0c 1 7fffffff 0 1
2 0a 00000003 00000005 0d 1 fffffffe 1 0
2 0b ffffffff 00000001 0e 1 00000001 1 0
2 0c ffffffff 00000001 0f 1 00000000 1 0
2 0b 80000000 7fffffff 10 1 00000001 1 0
3 0d 00000000 00000000 11 1 00000020 1 0
3 0d 00010000 00000000 12 1 0000000f 1 0
3 0e ffffffff 00000000 13 1 00000020 1 0
3 0e 7fffffff 00000000 14 1 00000000 1 0
4 0f fffffffe 00000003 15 0 fffffffa 0 0
4 12 00000000 00000000 16 1 ffffffff 1 0
4 13 00000000 00000000 17 1 fffffffa 1 0
4 10 fffffffe 00000003 18 0 fffffffa 0 0
4 12 00000000 00000000 19 1 00000002 1 0
4 11 0000ffff ffffffff 1a 1 ffff0001 1 0
4 12 00000000 00000000 1b 1 00000002 1 0
5 14 12345678 00000000 1c 0 00000000 0 0
5 13 00000000 00000000 1d 1 fffffffa 1 0
5 15 9abcdef0 00000000 1e 0 00000000 0 0
5 12 00000000 00000000 1f 1 12345678 1 0
5 13 00000000 00000000 00 1 9abcdef0 1 0
6 0f 80000000 80000000 01 0 00000000 0 0
6 12 00000000 00000000 02 1 40000000 1 0
6 13 00000000 00000000 03 1 00000000 1 0

// File: filelist.f
verilog/ex_pkg.sv
verilog/ex_logic_shift.sv
verilog/ex_arith.sv
verilog/ex_mul_iter.sv
verilog/ex_ctrl.sv
verilog/ex_top.sv
sim/ex_clkgen.sv
sim/ex_assert.sv
sim/ex_tb.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

TOP = ex_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail on errors"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if grep -q "Done: errors found" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
